/* src.f */
design/tx_cfg_pkg.sv
design/tlp_fmt_pkg.sv
design/tx_req_builder.sv
design/tx_rp_streamer.sv
design/tx_beat_queue.sv
design/tx_st_output.sv
design/tx_cntrl_top.sv
bench/tb_clk_gen.sv
bench/tx_cntrl_tb.sv

/* bench/tx_cntrl_tb.sv */
/*
 * testbench for the transmit control block, FIFO models,
 * a table of packets and an in-order beat checker
 */
module tx_cntrl_tb
  import tx_cfg_pkg::*, tlp_fmt_pkg::*;
();

  localparam int DRV_DLY = 1;
  localparam int CHK_DLY = 2;
  localparam int WAIT_LIMIT = 3000;
  localparam int QUIET_CYC = 24;
  localparam int MAX_ROWS = 24;
  localparam int MAX_TESTS = 8;
  localparam int KIND_RD = 0;
  localparam int KIND_WR = 1;
  localparam int KIND_RP = 2;
  localparam logic [7:0] EXP_FMT_RD = 8'h00;
  localparam logic [7:0] EXP_FMT_WR = 8'h40;
  localparam logic [BUSDEV_W-1:0] BUS_DEV = 13'h0a5b;

  logic                  clk;
  logic                  rstn;
  logic                  CmdFifoEmpty_i;
  logic [CMD_W-1:0]      CmdFifoDat_i;
  logic                  CmdFifoRdReq_o;
  logic [BEAT_W-1:0]     TxWrDat_i;
  logic                  WrDatFifoRdReq_o;
  logic [BUSDEV_W-1:0]   BusDev_i;
  logic                  RpTLPReady_i;
  logic [RP_ENTRY_W-1:0] TxRpFifoData_i;
  logic                  TxRpFifoRdReq_o;
  logic                  TxStReady_i;
  logic [BEAT_W-1:0]     TxStData_o;
  logic                  TxStSop_o;
  logic                  TxStEop_o;
  logic                  TxStValid_o;

  // packet table with one row per packet
  string            row_name  [MAX_ROWS];
  int               row_test  [MAX_ROWS];
  int               row_kind  [MAX_ROWS];
  logic [31:0]      row_addr  [MAX_ROWS];
  logic [LEN_W-1:0] row_len   [MAX_ROWS];
  logic [BE_W-1:0]  row_fbe   [MAX_ROWS];
  logic [BE_W-1:0]  row_lbe   [MAX_ROWS];
  logic [TAG_W-1:0] row_tag   [MAX_ROWS];
  logic [31:0]      row_seed  [MAX_ROWS];
  int               row_beats [MAX_ROWS];
  int               row_words [MAX_ROWS];
  int               n_rows;
  string            test_name [MAX_TESTS];
  logic             test_rand [MAX_TESTS];
  int               n_tests;

  // FIFO model contents and beat lists with beats as {eop, sop, data}
  logic [CMD_W-1:0]      cmd_q [$];
  logic [BEAT_W-1:0]     wr_q [$];
  logic [RP_ENTRY_W-1:0] rp_q [$];
  logic [BEAT_W+1:0]     exp_q [$];
  int                    exp_row_q [$];
  logic [BEAT_W+1:0]     rx_q [$];

  int          rp_pending;
  int          wr_pops;
  logic        rand_ready;
  logic        in_pkt;
  logic [31:0] lcg_state;
  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;

  tb_clk_gen clk_gen_i (.clk_o(clk), .rstn_o(rstn));

  tx_cntrl_top dut_i (
    .Clk_i(clk), .Rstn_i(rstn),
    .CmdFifoEmpty_i(CmdFifoEmpty_i), .CmdFifoDat_i(CmdFifoDat_i),
    .CmdFifoRdReq_o(CmdFifoRdReq_o), .TxWrDat_i(TxWrDat_i),
    .WrDatFifoRdReq_o(WrDatFifoRdReq_o), .BusDev_i(BusDev_i),
    .RpTLPReady_i(RpTLPReady_i), .TxRpFifoData_i(TxRpFifoData_i),
    .TxRpFifoRdReq_o(TxRpFifoRdReq_o), .TxStReady_i(TxStReady_i),
    .TxStData_o(TxStData_o), .TxStSop_o(TxStSop_o),
    .TxStEop_o(TxStEop_o), .TxStValid_o(TxStValid_o)
  );

  function automatic logic next_ready();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // ready about three cycles in four
    return (lcg_state[17:16] != 2'b00);
  endfunction

  function automatic logic [63:0] data_word(input logic [31:0] seed, input int k);
    logic [31:0] lo;
    logic [31:0] hi;
    lo = seed + 32'h0001_0003 * k;
    hi = ~seed ^ (32'h0101_0101 * k);
    return {hi, lo};
  endfunction

  // 64-bit words spanned by the payload whose first dword lands at addr bit 2
  function automatic int word_count(input int r);
    return (int'(row_len[r]) + int'(row_addr[r][2]) + 1) / 2;
  endfunction

  function automatic logic [63:0] hdr1_word(input int r);
    logic [7:0] fmt;
    fmt = (row_kind[r] == KIND_WR) ? EXP_FMT_WR : EXP_FMT_RD;
    return {BUS_DEV, 3'b000, row_tag[r], row_lbe[r], row_fbe[r], fmt,
            8'h00, 6'b000000, row_len[r]};
  endfunction

  function automatic logic [CMD_W-1:0] cmd_word(input int r);
    logic [CMD_W-1:0] w;
    w = '0;
    w[CMD_ADDR_LSB +: 32]   = row_addr[r];
    w[CMD_RD_BIT]           = (row_kind[r] == KIND_RD);
    w[CMD_WR_BIT]           = (row_kind[r] == KIND_WR);
    w[CMD_FBE_LSB +: BE_W]  = row_fbe[r];
    w[CMD_TAG_LSB +: TAG_W] = row_tag[r];
    w[CMD_LEN_LSB +: LEN_W] = row_len[r];
    w[CMD_LBE_LSB +: BE_W]  = row_lbe[r];
    return w;
  endfunction

  task automatic add_row(input string name, input int test, input int kind,
                         input logic [31:0] addr, input logic [LEN_W-1:0] len,
                         input logic [3:0] fbe, input logic [3:0] lbe,
                         input logic [7:0] tag, input logic [31:0] seed,
                         input int beats, input int words);
    row_name[n_rows]  = name;
    row_test[n_rows]  = test;
    row_kind[n_rows]  = kind;
    row_addr[n_rows]  = addr;
    row_len[n_rows]   = len;
    row_fbe[n_rows]   = fbe;
    row_lbe[n_rows]   = lbe;
    row_tag[n_rows]   = tag;
    row_seed[n_rows]  = seed;
    row_beats[n_rows] = beats;
    row_words[n_rows] = words;
    n_rows++;
  endtask

  task automatic add_test(input string name, input logic rnd);
    test_name[n_tests] = name;
    test_rand[n_tests] = rnd;
    n_tests++;
  endtask

  task automatic build_table();
    n_rows  = 0;
    n_tests = 0;
    add_test("read_len1", 1'b0);
    add_row("rd1", 0, KIND_RD, 32'h1000_0040, 10'd1, 4'hf, 4'h0, 8'h11, 32'h0, 2, 0);
    add_test("write_len4", 1'b0);
    add_row("wr4", 1, KIND_WR, 32'h2000_0100, 10'd4, 4'hf, 4'hf, 8'h22, 32'ha5a5_0001, 4, 2);
    add_test("write_dw_offset", 1'b0);
    add_row("wr3_odd", 2, KIND_WR, 32'h2000_0204, 10'd3, 4'he, 4'h3, 8'h33, 32'h1234_0000, 3, 2);
    add_row("wr1_odd", 2, KIND_WR, 32'h2000_030c, 10'd1, 4'hc, 4'h0, 8'h34, 32'h5678_0000, 2, 1);
    add_test("rp_two_entries", 1'b0);
    add_row("rp2", 3, KIND_RP, 32'h0, 10'd2, 4'h0, 4'h0, 8'h00, 32'hc0de_0000, 4, 0);
    add_test("mixed_random_ready", 1'b1);
    add_row("m_rd2", 4, KIND_RD, 32'h3000_0008, 10'd2, 4'hf, 4'hf, 8'h40, 32'h0, 2, 0);
    add_row("m_wr7", 4, KIND_WR, 32'h3000_1000, 10'd7, 4'hf, 4'h1, 8'h41, 32'h0700_0000, 6, 4);
    add_row("m_rp3", 4, KIND_RP, 32'h0, 10'd3, 4'h0, 4'h0, 8'h00, 32'hbeef_0000, 6, 0);
    add_row("m_wr6", 4, KIND_WR, 32'h3000_2004, 10'd6, 4'h8, 4'h7, 8'h42, 32'h0600_0000, 5, 4);
    add_row("m_rd16", 4, KIND_RD, 32'h3000_0100, 10'd16, 4'hf, 4'hf, 8'h43, 32'h0, 2, 0);
    add_row("m_wr20", 4, KIND_WR, 32'h3000_3000, 10'd20, 4'hf, 4'hf, 8'h44, 32'h2000_0000, 12, 10);
    add_row("m_rp1", 4, KIND_RP, 32'h0, 10'd1, 4'h0, 4'h0, 8'h00, 32'hfeed_0000, 2, 0);
    add_row("m_wr2", 4, KIND_WR, 32'h3000_4004, 10'd2, 4'hc, 4'h3, 8'h45, 32'h0200_0000, 3, 2);
    add_test("rp_behind_commands", 1'b1);
    add_row("c_wr10", 5, KIND_WR, 32'h4000_0000, 10'd10, 4'hf, 4'hf, 8'h50, 32'h1000_0000, 7, 5);
    add_row("c_rp3", 5, KIND_RP, 32'h0, 10'd3, 4'h0, 4'h0, 8'h00, 32'hcafe_0000, 6, 0);
    add_row("c_rd1", 5, KIND_RD, 32'h4000_0040, 10'd1, 4'h3, 4'h0, 8'h51, 32'h0, 2, 0);
    add_row("c_wr5", 5, KIND_WR, 32'h4000_0104, 10'd5, 4'hf, 4'hf, 8'h52, 32'h0500_0000, 4, 3);
  endtask

  task automatic push_exp(input int r, input logic eop, input logic sop,
                          input logic [63:0] data);
    exp_q.push_back({eop, sop, data});
    exp_row_q.push_back(r);
  endtask

  task automatic expect_row(input int r);
    logic [63:0] w0;
    int          nw;
    int          k;
    nw = word_count(r);
    if (row_kind[r] == KIND_RD)
    begin
      push_exp(r, 1'b0, 1'b1, hdr1_word(r));
      push_exp(r, 1'b1, 1'b0, {32'h0, row_addr[r]});
    end
    else if (row_kind[r] == KIND_WR)
    begin
      push_exp(r, 1'b0, 1'b1, hdr1_word(r));
      if (row_addr[r][2])
      begin
        // first dword sits in the upper half of word 0
        w0 = data_word(row_seed[r], 0);
        push_exp(r, (nw == 1), 1'b0, {w0[63:32], row_addr[r]});
        for (k = 1; k < nw; k++)
          push_exp(r, (k == nw - 1), 1'b0, data_word(row_seed[r], k));
      end
      else
      begin
        push_exp(r, 1'b0, 1'b0, {32'h0, row_addr[r]});
        for (k = 0; k < nw; k++)
          push_exp(r, (k == nw - 1), 1'b0, data_word(row_seed[r], k));
      end
    end
    else
    begin
      for (k = 0; k < int'(row_len[r]); k++)
      begin
        push_exp(r, 1'b0, (k == 0), data_word(row_seed[r], 2 * k));
        push_exp(r, (k == int'(row_len[r]) - 1), 1'b0, data_word(row_seed[r], 2 * k + 1));
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #CHK_DLY;
  endtask

  task automatic wait_cmd_drained(input int t);
    int cnt;
    cnt = 0;
    while (cmd_q.size() != 0 && cnt < WAIT_LIMIT)
    begin
      next_cycle();
      cnt++;
    end
    if (cmd_q.size() != 0)
    begin
      $display("timeout: command FIFO not drained in test %s", test_name[t]);
      timed_out = 1'b1;
      err_cnt++;
    end
  endtask

  task automatic wait_beats(input int t, input int n);
    int cnt;
    cnt = 0;
    while (rx_q.size() < n && cnt < WAIT_LIMIT)
    begin
      next_cycle();
      cnt++;
    end
    if (rx_q.size() < n)
    begin
      $display("timeout: test %s received %0d of %0d beats", test_name[t], rx_q.size(), n);
      timed_out = 1'b1;
      err_cnt++;
    end
  endtask

  task automatic load_row(input int t, input int r);
    int k;
    if (row_kind[r] == KIND_RP)
    begin
      // earlier commands must be taken before the packet shows up
      wait_cmd_drained(t);
      for (k = 0; k < int'(row_len[r]); k++)
        rp_q.push_back({(k == int'(row_len[r]) - 1), (k == 0),
                        data_word(row_seed[r], 2 * k + 1), data_word(row_seed[r], 2 * k)});
      rp_pending++;
    end
    else
    begin
      if (row_kind[r] == KIND_WR)
        for (k = 0; k < word_count(r); k++)
          wr_q.push_back(data_word(row_seed[r], k));
      cmd_q.push_back(cmd_word(r));
    end
  endtask

  task automatic compare_beats(input int t);
    int i;
    for (i = 0; i < exp_q.size() && i < rx_q.size(); i++)
    begin
      if (rx_q[i] !== exp_q[i])
      begin
        $display("mismatch %s (%s) beat %0d expected %h actual %h",
                 test_name[t], row_name[exp_row_q[i]], i, exp_q[i], rx_q[i]);
        err_cnt++;
      end
    end
    if (rx_q.size() < exp_q.size())
    begin
      $display("test %s is missing %0d beats", test_name[t], exp_q.size() - rx_q.size());
      err_cnt++;
    end
    if (rx_q.size() > exp_q.size())
    begin
      $display("test %s got %0d beats more than expected", test_name[t],
               rx_q.size() - exp_q.size());
      err_cnt++;
    end
  endtask

  task automatic run_test(input int t);
    int r;
    int i;
    int err_start;
    int beat_sum;
    int word_sum;
    err_start = err_cnt;
    beat_sum  = 0;
    word_sum  = 0;
    exp_q.delete();
    exp_row_q.delete();
    rx_q.delete();
    wr_pops    = 0;
    rand_ready = test_rand[t];
    for (r = 0; r < n_rows; r++)
    begin
      if (row_test[r] == t)
      begin
        expect_row(r);
        beat_sum += row_beats[r];
        word_sum += row_words[r];
      end
    end
    for (r = 0; r < n_rows && !timed_out; r++)
      if (row_test[r] == t)
        load_row(t, r);
    if (!timed_out)
      wait_beats(t, exp_q.size());
    // window for late or repeated beats
    for (i = 0; i < QUIET_CYC && !timed_out; i++)
      next_cycle();
    compare_beats(t);
    if (rx_q.size() != beat_sum)
    begin
      $display("mismatch %s beat count expected %0d actual %0d",
               test_name[t], beat_sum, rx_q.size());
      err_cnt++;
    end
    if (wr_pops != word_sum)
    begin
      $display("mismatch %s write words consumed expected %0d actual %0d",
               test_name[t], word_sum, wr_pops);
      err_cnt++;
    end
    if (cmd_q.size() != 0 || wr_q.size() != 0 || rp_q.size() != 0)
    begin
      $display("test %s left entries unread in the FIFO models", test_name[t]);
      err_cnt++;
    end
    $display("test %s: %0d beats, %0d errors", test_name[t], rx_q.size(), err_cnt - err_start);
    tests_run++;
    if (err_cnt != err_start)
      tests_failed++;
  endtask

  // FIFO models sample requests before the edge and answer after it
  initial
  begin : fifo_models
    logic cmd_pop;
    logic wr_pop;
    logic rp_pop;
    logic [RP_ENTRY_W-1:0] entry;
    lcg_state      = 32'd99;
    rand_ready     = 1'b0;
    rp_pending     = 0;
    wr_pops        = 0;
    CmdFifoEmpty_i = 1'b1;
    CmdFifoDat_i   = '0;
    TxWrDat_i      = '0;
    BusDev_i       = BUS_DEV;
    RpTLPReady_i   = 1'b0;
    TxRpFifoData_i = '0;
    TxStReady_i    = 1'b1;
    forever
    begin
      @(negedge clk);
      cmd_pop = CmdFifoRdReq_o;
      wr_pop  = WrDatFifoRdReq_o;
      rp_pop  = TxRpFifoRdReq_o;
      @(posedge clk);
      #DRV_DLY;
      if (cmd_pop)
      begin
        if (cmd_q.size() == 0)
        begin
          $display("command FIFO read while empty");
          err_cnt++;
        end
        else
          CmdFifoDat_i = cmd_q.pop_front();
      end
      if (wr_pop)
      begin
        wr_pops++;
        if (wr_q.size() == 0)
        begin
          $display("write-data FIFO read while empty");
          err_cnt++;
        end
        else
          void'(wr_q.pop_front());
      end
      if (rp_pop)
      begin
        if (rp_q.size() == 0)
        begin
          $display("root-port FIFO read while empty");
          err_cnt++;
        end
        else
        begin
          entry = rp_q.pop_front();
          TxRpFifoData_i = entry;
          // a started packet is no longer waiting
          if (entry[RP_ENTRY_W-2])
            rp_pending--;
        end
      end
      CmdFifoEmpty_i = (cmd_q.size() == 0);
      TxWrDat_i      = (wr_q.size() != 0) ? wr_q[0] : '0;
      RpTLPReady_i   = (rp_pending > 0);
      TxStReady_i    = rand_ready ? next_ready() : 1'b1;
    end
  end

  // beat collector with packet framing checks
  always @(negedge clk)
  begin
    if (rstn && TxStValid_o)
    begin
      rx_q.push_back({TxStEop_o, TxStSop_o, TxStData_o});
      if (TxStSop_o && in_pkt)
      begin
        $display("start of packet seen while another packet is still open");
        err_cnt++;
      end
      if (!TxStSop_o && !in_pkt)
      begin
        $display("beat seen outside of any packet");
        err_cnt++;
      end
      in_pkt = !TxStEop_o;
    end
  end

  initial
  begin : main_flow
    int t;
    int cnt;
    int err_start;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    in_pkt       = 1'b0;
    build_table();
    // outputs while reset is held
    @(negedge clk);
    err_start = err_cnt;
    if (CmdFifoRdReq_o || WrDatFifoRdReq_o || TxRpFifoRdReq_o ||
        TxStValid_o || TxStSop_o || TxStEop_o)
    begin
      $display("request or stream outputs are active during reset");
      err_cnt++;
    end
    $display("test reset_values: %0d errors", err_cnt - err_start);
    tests_run++;
    if (err_cnt != err_start)
      tests_failed++;
    cnt = 0;
    while (!rstn && cnt < WAIT_LIMIT)
    begin
      next_cycle();
      cnt++;
    end
    if (!rstn)
    begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
      err_cnt++;
    end
    for (t = 0; t < n_tests && !timed_out; t++)
      run_test(t);
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* bench/tb_clk_gen.sv */
/*
 * testbench clock and reset source
 */
module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 2;

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset released just after the second rising edge
  initial
  begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rstn_o = 1'b1;
  end

endmodule

/* design/tx_cntrl_top.sv */
/*
 * transmit control top, request builder and root-port streamer
 * feeding the output queue and the streaming port
 */
module tx_cntrl_top
  import tx_cfg_pkg::*, tlp_fmt_pkg::*;
(
  input  logic                  Clk_i,
  input  logic                  Rstn_i,
  input  logic                  CmdFifoEmpty_i,
  input  logic [CMD_W-1:0]      CmdFifoDat_i,
  output logic                  CmdFifoRdReq_o,
  input  logic [BEAT_W-1:0]     TxWrDat_i,
  output logic                  WrDatFifoRdReq_o,
  input  logic [BUSDEV_W-1:0]   BusDev_i,
  input  logic                  RpTLPReady_i,
  input  logic [RP_ENTRY_W-1:0] TxRpFifoData_i,
  output logic                  TxRpFifoRdReq_o,
  input  logic                  TxStReady_i,
  output logic [BEAT_W-1:0]     TxStData_o,
  output logic                  TxStSop_o,
  output logic                  TxStEop_o,
  output logic                  TxStValid_o
);

  logic              req_idle;
  logic              rp_busy;
  logic              room_ok;
  logic              req_wr;
  logic [BEAT_W-1:0] req_data;
  logic              req_sop;
  logic              req_eop;
  logic              rp_wr;
  logic [BEAT_W-1:0] rp_data;
  logic              rp_sop;
  logic              rp_eop;
  logic              q_pop;
  logic              q_empty;
  logic [BEAT_W-1:0] q_data;
  logic              q_sop;
  logic              q_eop;

  tx_req_builder req_builder_i (
    .Clk_i(Clk_i), .Rstn_i(Rstn_i),
    .CmdFifoEmpty_i(CmdFifoEmpty_i), .CmdFifoDat_i(CmdFifoDat_i),
    .CmdFifoRdReq_o(CmdFifoRdReq_o), .TxWrDat_i(TxWrDat_i),
    .WrDatFifoRdReq_o(WrDatFifoRdReq_o), .BusDev_i(BusDev_i),
    .RpTLPReady_i(RpTLPReady_i), .rp_busy_i(rp_busy), .room_ok_i(room_ok),
    .req_idle_o(req_idle), .beat_wr_o(req_wr), .beat_data_o(req_data),
    .beat_sop_o(req_sop), .beat_eop_o(req_eop)
  );

  tx_rp_streamer rp_streamer_i (
    .Clk_i(Clk_i), .Rstn_i(Rstn_i),
    .RpTLPReady_i(RpTLPReady_i), .TxRpFifoData_i(TxRpFifoData_i),
    .req_idle_i(req_idle), .room_ok_i(room_ok),
    .TxRpFifoRdReq_o(TxRpFifoRdReq_o), .rp_busy_o(rp_busy),
    .beat_wr_o(rp_wr), .beat_data_o(rp_data),
    .beat_sop_o(rp_sop), .beat_eop_o(rp_eop)
  );

  tx_beat_queue beat_queue_i (
    .Clk_i(Clk_i), .Rstn_i(Rstn_i),
    .req_wr_i(req_wr), .req_data_i(req_data), .req_sop_i(req_sop), .req_eop_i(req_eop),
    .rp_wr_i(rp_wr), .rp_data_i(rp_data), .rp_sop_i(rp_sop), .rp_eop_i(rp_eop),
    .rp_busy_i(rp_busy), .pop_i(q_pop), .room_ok_o(room_ok), .q_empty_o(q_empty),
    .q_data_o(q_data), .q_sop_o(q_sop), .q_eop_o(q_eop)
  );

  tx_st_output st_output_i (
    .Clk_i(Clk_i), .Rstn_i(Rstn_i),
    .q_empty_i(q_empty), .q_data_i(q_data), .q_sop_i(q_sop), .q_eop_i(q_eop),
    .TxStReady_i(TxStReady_i), .pop_o(q_pop),
    .TxStData_o(TxStData_o), .TxStSop_o(TxStSop_o),
    .TxStEop_o(TxStEop_o), .TxStValid_o(TxStValid_o)
  );

endmodule

/* design/tx_st_output.sv */
/*
 * registered output stage towards the PCIe core streaming port
 */
module tx_st_output
  import tx_cfg_pkg::*;
(
  input  logic              Clk_i,
  input  logic              Rstn_i,
  input  logic              q_empty_i,
  input  logic [BEAT_W-1:0] q_data_i,
  input  logic              q_sop_i,
  input  logic              q_eop_i,
  input  logic              TxStReady_i,
  output logic              pop_o,
  output logic [BEAT_W-1:0] TxStData_o,
  output logic              TxStSop_o,
  output logic              TxStEop_o,
  output logic              TxStValid_o
);

  logic fetch_vld;
  logic out_vld;
  logic ready_q;
  logic out_xfer;
  logic fetch_take;

  // held beat leaves when the core was ready last cycle
  assign out_xfer   = out_vld & ready_q;
  assign fetch_take = fetch_vld & (~out_vld | out_xfer);
  assign pop_o      = ~q_empty_i & (~fetch_vld | fetch_take);

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      ready_q   <= 1'b0;
      fetch_vld <= 1'b0;
      out_vld   <= 1'b0;
      TxStSop_o <= 1'b0;
      TxStEop_o <= 1'b0;
    end
    else
    begin
      ready_q <= TxStReady_i;
      if (pop_o)
        fetch_vld <= 1'b1;
      else if (fetch_take)
        fetch_vld <= 1'b0;
      if (fetch_take)
      begin
        out_vld   <= 1'b1;
        TxStSop_o <= q_sop_i;
        TxStEop_o <= q_eop_i;
      end
      else if (out_xfer)
      begin
        out_vld   <= 1'b0;
        TxStSop_o <= 1'b0;
        TxStEop_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (fetch_take)
      TxStData_o <= q_data_i;
  end

  assign TxStValid_o = out_xfer;

endmodule

/* design/tx_beat_queue.sv */
/*
 * merges the two beat sources into the 16-entry output queue
 */
module tx_beat_queue
  import tx_cfg_pkg::*;
(
  input  logic              Clk_i,
  input  logic              Rstn_i,
  input  logic              req_wr_i,
  input  logic [BEAT_W-1:0] req_data_i,
  input  logic              req_sop_i,
  input  logic              req_eop_i,
  input  logic              rp_wr_i,
  input  logic [BEAT_W-1:0] rp_data_i,
  input  logic              rp_sop_i,
  input  logic              rp_eop_i,
  input  logic              rp_busy_i,
  input  logic              pop_i,
  output logic              room_ok_o,
  output logic              q_empty_o,
  output logic [BEAT_W-1:0] q_data_o,
  output logic              q_sop_o,
  output logic              q_eop_o
);

  logic                in_wr;
  logic [BEAT_W+1:0]   in_beat;
  logic                in_wr_q;
  logic [BEAT_W+1:0]   in_beat_q;
  logic [BEAT_W+1:0]   mem [QUEUE_DEPTH];
  logic [QUEUE_AW-1:0] wr_ptr;
  logic [QUEUE_AW-1:0] rd_ptr;
  logic [QUEUE_AW:0]   fill_cnt;
  logic [BEAT_W+1:0]   rd_beat;

  // streamer owns the queue while it is busy
  assign in_wr   = rp_busy_i ? rp_wr_i : req_wr_i;
  assign in_beat = rp_busy_i ? {rp_eop_i, rp_sop_i, rp_data_i}
                             : {req_eop_i, req_sop_i, req_data_i};

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      in_wr_q <= 1'b0;
    else
      in_wr_q <= in_wr;
  end

  always_ff @(posedge Clk_i)
  begin
    in_beat_q <= in_beat;
    if (in_wr_q)
      mem[wr_ptr] <= in_beat_q;
    if (pop_i)
      rd_beat <= mem[rd_ptr];
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill_cnt  <= '0;
      room_ok_o <= 1'b1;
    end
    else
    begin
      if (in_wr_q)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      fill_cnt  <= fill_cnt + in_wr_q - pop_i;
      room_ok_o <= (fill_cnt <= QUEUE_ROOM_MAX);
    end
  end

  assign q_empty_o = (fill_cnt == '0);
  assign q_data_o  = rd_beat[BEAT_W-1:0];
  assign q_sop_o   = rd_beat[BEAT_W];
  assign q_eop_o   = rd_beat[BEAT_W+1];

endmodule

/* design/tx_rp_streamer.sv */
/*
 * root-port pass-through, splits 128-bit FIFO entries into beats
 */
module tx_rp_streamer
  import tx_cfg_pkg::*;
(
  input  logic                  Clk_i,
  input  logic                  Rstn_i,
  input  logic                  RpTLPReady_i,
  input  logic [RP_ENTRY_W-1:0] TxRpFifoData_i,
  input  logic                  req_idle_i,
  input  logic                  room_ok_i,
  output logic                  TxRpFifoRdReq_o,
  output logic                  rp_busy_o,
  output logic                  beat_wr_o,
  output logic [BEAT_W-1:0]     beat_data_o,
  output logic                  beat_sop_o,
  output logic                  beat_eop_o
);

  typedef enum logic [1:0] {
    RP_IDLE,
    RP_POP,
    RP_LOW,
    RP_HIGH
  } rp_state_t;

  rp_state_t state;
  rp_state_t nxt_state;

  logic entry_sop;
  logic entry_eop;
  logic pop_next;

  assign entry_sop = TxRpFifoData_i[RP_ENTRY_W-2];
  assign entry_eop = TxRpFifoData_i[RP_ENTRY_W-1];

  // back to back entries pop during the high half
  assign pop_next = (state == RP_HIGH) & ~entry_eop & room_ok_i;

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state <= RP_IDLE;
    else
      state <= nxt_state;
  end

  always_comb
  begin
    nxt_state = state;
    case (state)
      RP_IDLE:
        if (RpTLPReady_i & req_idle_i)
          nxt_state = RP_POP;
      RP_POP:
        if (room_ok_i)
          nxt_state = RP_LOW;
      RP_LOW:
        nxt_state = RP_HIGH;
      RP_HIGH:
        if (entry_eop)
          nxt_state = RP_IDLE;
        else if (room_ok_i)
          nxt_state = RP_LOW;
        else
          nxt_state = RP_POP;
      default:
        nxt_state = RP_IDLE;
    endcase
  end

  assign TxRpFifoRdReq_o = ((state == RP_POP) & room_ok_i) | pop_next;
  assign rp_busy_o = (state != RP_IDLE);

  assign beat_wr_o   = (state == RP_LOW) | (state == RP_HIGH);
  assign beat_data_o = (state == RP_HIGH) ? TxRpFifoData_i[2*BEAT_W-1:BEAT_W]
                                          : TxRpFifoData_i[BEAT_W-1:0];
  assign beat_sop_o  = (state == RP_LOW) & entry_sop;
  assign beat_eop_o  = (state == RP_HIGH) & entry_eop;

endmodule

/* design/tx_req_builder.sv */
/*
 * builds memory read and write TLPs from the command FIFO
 * and the show-ahead write-data FIFO
 */
module tx_req_builder
  import tx_cfg_pkg::*, tlp_fmt_pkg::*;
(
  input  logic                Clk_i,
  input  logic                Rstn_i,
  input  logic                CmdFifoEmpty_i,
  input  logic [CMD_W-1:0]    CmdFifoDat_i,
  output logic                CmdFifoRdReq_o,
  input  logic [BEAT_W-1:0]   TxWrDat_i,
  output logic                WrDatFifoRdReq_o,
  input  logic [BUSDEV_W-1:0] BusDev_i,
  input  logic                RpTLPReady_i,
  input  logic                rp_busy_i,
  input  logic                room_ok_i,
  output logic                req_idle_o,
  output logic                beat_wr_o,
  output logic [BEAT_W-1:0]   beat_data_o,
  output logic                beat_sop_o,
  output logic                beat_eop_o
);

  typedef enum logic [5:0] {
    B_IDLE   = 6'b000001,
    B_DECODE = 6'b000010,
    B_HDR1   = 6'b000100,
    B_HDR2   = 6'b001000,
    B_DATA   = 6'b010000,
    B_WAIT   = 6'b100000
  } bld_state_t;

  bld_state_t state;
  bld_state_t nxt_state;

  logic [LEN_W-1:0]  cmd_len;
  logic              cmd_bit2;
  logic              is_wr_q;
  logic [31:0]       addr_q;
  logic [TAG_W-1:0]  tag_q;
  logic [BE_W-1:0]   fbe_q;
  logic [BE_W-1:0]   lbe_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W:0]    dw_cnt;
  logic              last_cnt;
  logic              short_wr;
  logic              data_go;
  logic [7:0]        fmt_type;
  logic [BEAT_W-1:0] header1;
  logic [BEAT_W-1:0] header2;

  assign cmd_len  = CmdFifoDat_i[CMD_LEN_LSB +: LEN_W];
  assign cmd_bit2 = CmdFifoDat_i[CMD_ADDR_LSB + 2];

  assign last_cnt = (dw_cnt == 'd2);
  // write whose only dword rides in header 2
  assign short_wr = is_wr_q & addr_q[2] & last_cnt;
  assign data_go  = (state == B_DATA) & room_ok_i;

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state <= B_IDLE;
    else
      state <= nxt_state;
  end

  always_comb
  begin
    nxt_state = state;
    case (state)
      B_IDLE:
        if (CmdFifoRdReq_o)
          nxt_state = B_DECODE;
      B_DECODE:
        if (CmdFifoDat_i[CMD_RD_BIT] | CmdFifoDat_i[CMD_WR_BIT])
          nxt_state = B_HDR1;
        else
          nxt_state = B_IDLE;
      B_HDR1:
        nxt_state = B_HDR2;
      B_HDR2:
        if (!is_wr_q || short_wr)
          nxt_state = B_IDLE;
        else
          nxt_state = B_DATA;
      B_DATA:
        if (!room_ok_i)
          nxt_state = B_WAIT;
        else if (last_cnt)
          nxt_state = B_IDLE;
      B_WAIT:
        if (room_ok_i)
          nxt_state = B_DATA;
      default:
        nxt_state = B_IDLE;
    endcase
  end

  // command fields, captured in the decode cycle
  always_ff @(posedge Clk_i)
  begin
    if (state == B_DECODE)
    begin
      is_wr_q <= CmdFifoDat_i[CMD_WR_BIT];
      addr_q  <= CmdFifoDat_i[CMD_ADDR_LSB +: 32];
      tag_q   <= CmdFifoDat_i[CMD_TAG_LSB +: TAG_W];
      fbe_q   <= CmdFifoDat_i[CMD_FBE_LSB +: BE_W];
      lbe_q   <= CmdFifoDat_i[CMD_LBE_LSB +: BE_W];
      len_q   <= cmd_len;
    end
  end

  // dwords still to send, padded up to whole words
  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      dw_cnt <= '0;
    else if (state == B_DECODE)
    begin
      if (cmd_len[0])
        dw_cnt <= {1'b0, cmd_len} + 'd1;
      else if (cmd_bit2)
        dw_cnt <= {1'b0, cmd_len} + 'd2;
      else
        dw_cnt <= {1'b0, cmd_len};
    end
    else if (((state == B_HDR2) & is_wr_q & addr_q[2]) | data_go)
      dw_cnt <= dw_cnt - 'd2;
  end

  assign fmt_type = is_wr_q ? FMT_MWR32 : FMT_MRD32;

  assign header1 = {BusDev_i, 3'b000, tag_q, lbe_q, fbe_q, fmt_type,
                    8'h00, 6'b000000, len_q};
  // odd start address puts dword 0 next to the address
  assign header2 = {(is_wr_q & addr_q[2]) ? TxWrDat_i[BEAT_W-1:BEAT_W/2] : 32'h0, addr_q};

  assign CmdFifoRdReq_o = (state == B_IDLE) & ~CmdFifoEmpty_i & ~rp_busy_i &
                          ~RpTLPReady_i & room_ok_i;
  assign WrDatFifoRdReq_o = ((state == B_HDR2) & is_wr_q & addr_q[2]) | data_go;
  assign req_idle_o = (state == B_IDLE);

  assign beat_wr_o  = (state == B_HDR1) | (state == B_HDR2) | data_go;
  assign beat_sop_o = (state == B_HDR1);
  assign beat_eop_o = ((state == B_HDR2) & (~is_wr_q | short_wr)) | (data_go & last_cnt);

  always_comb
  begin
    case (state)
      B_HDR1:  beat_data_o = header1;
      B_HDR2:  beat_data_o = header2;
      default: beat_data_o = TxWrDat_i;
    endcase
  end

endmodule

/* design/tlp_fmt_pkg.sv */
/*
 * TLP header field widths and format/type codes
 */
package tlp_fmt_pkg;

  // length field of header dword 0
  localparam int LEN_W = 10;

  // request tag
  localparam int TAG_W = 8;

  // first and last byte enable fields
  localparam int BE_W = 4;

  // bus and device number, function is always 0
  localparam int BUSDEV_W = 13;

  // format/type byte for 3-dword headers
  // bit 6 set means the TLP carries data
  localparam logic [7:0] FMT_MRD32 = 8'h00;
  localparam logic [7:0] FMT_MWR32 = 8'h40;

  // header dword 0 layout, from the top of beat 1
  //   requester id   16
  //   tag             8
  //   lbe, fbe        8
  //   fmt/type        8
  //   tc/attr         8
  //   td/ep/rsvd      6
  //   length         10
  //
  // header beat 2 carries the address in its low half
  // and either zero or the first payload dword on top

endpackage

/* design/tx_cfg_pkg.sv */
/*
 * transmit path sizing and command word layout
 */
package tx_cfg_pkg;

  // one beat on the streaming interface
  localparam int BEAT_W = 64;

  // command word from the bridge command FIFO
  localparam int CMD_W = 60;

  // address, 32 bits starting here
  localparam int CMD_ADDR_LSB = 0;

  // request kind flags
  localparam int CMD_RD_BIT = 32;
  localparam int CMD_WR_BIT = 33;

  // first byte enables, 4 bits
  localparam int CMD_FBE_LSB = 34;

  // tag, 8 bits
  localparam int CMD_TAG_LSB = 38;

  // dword length, 10 bits
  localparam int CMD_LEN_LSB = 46;

  // last byte enables, 4 bits
  localparam int CMD_LBE_LSB = 56;

  // root-port entry: two beats of data, then sop and eop on top
  localparam int RP_ENTRY_W = 130;

  // output queue
  localparam int QUEUE_DEPTH = 16;
  localparam int QUEUE_AW = 4;

  // room while the fill count is at or below this
  // the rest covers beats in flight and two header beats
  localparam int QUEUE_ROOM_MAX = 4;

endpackage
